// File: fetch_if.sv
`timescale 1ns/100ps

interface fetch_if;

    // current fetch PC
    fetch_pkg::pc_t        pc;

    // aligned 32-bit instruction for pc
    fetch_pkg::inst_word_t instr;

    // pc and instr hold a real instruction this cycle
    logic                  valid;

    // interrupt strobe, predecode drops its redirects when set
    logic                  intr;

    modport src (
        output pc,
        output instr,
        output valid,
        output intr
    );

    modport dst (
        input pc,
        input instr,
        input valid,
        input intr
    );

endinterface

// File: fetch_pkg.sv
package fetch_pkg;

    // datapath widths
    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    // the first increment lands on the boot address 0x8000_0000
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000 - 64'd4;

    // 256 memory words, addressed by pc[10:3]
    localparam int IMEM_AW = 8;

    // opcodes seen by predecode
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // privileged SYSTEM encodings
    localparam logic [2:0]  FUNCT3_PRIV = 3'b000;
    localparam logic [11:0] FUNCT_ECALL = 12'h000;
    localparam logic [11:0] FUNCT_MRET  = 12'h302;

    typedef logic [XLEN-1:0] pc_t;

    // I-type view, SYSTEM instructions are recognized through this one
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // J-type view, immediate bits are scattered
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, two decodings
    typedef union packed {
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_word_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fetch_pkg::pc_t             pc_i,
    input  logic [fetch_pkg::XLEN-1:0] rdata_i,
    input  logic                       intr_i,
    fetch_if.src                       out
);

    logic                  started_q;
    fetch_pkg::inst_word_t instr;

    // low until the first clock after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started_q <= 1'b0;
        end else begin
            started_q <= 1'b1;
        end
    end

    // pc[2] picks the upper word half
    always_comb begin
        if (pc_i[2]) begin
            instr = rdata_i[63:32];
        end else begin
            instr = rdata_i[31:0];
        end
    end

    assign out.pc    = pc_i;
    assign out.instr = instr;

    // the reset pc never addresses a real instruction
    assign out.valid = started_q && (pc_i != fetch_pkg::RESET_PC);
    assign out.intr  = intr_i;

    // every pc that reaches predecode comes from pc_gen 4-byte aligned
    a_valid_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        out.valid |-> (pc_i[1:0] == 2'b00)
    ) else $error("fetch_stage: valid pc %h not aligned", pc_i);

endmodule

// File: fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          intr_i,
    input  fetch_pkg::pc_t                csr_mtvec_i,
    input  fetch_pkg::pc_t                csr_mepc_i,
    input  logic                          imem_we_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_i,
    input  logic [fetch_pkg::XLEN-1:0]    imem_wdata_i,
    output logic                          out_valid_o,
    output fetch_pkg::pc_t                out_pc_o,
    output fetch_pkg::inst_word_t         out_instr_o,
    output logic                          out_is_jump_o,
    output logic                          out_is_trap_o
);

    fetch_pkg::pc_t             pc;
    fetch_pkg::pc_t             pc_next;
    fetch_pkg::pc_t             jump_pc;
    logic                       jump;
    logic                       trap_enter;
    logic                       trap_ret;
    logic [fetch_pkg::XLEN-1:0] rdata;

    fetch_if fif ();

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .intr_i       (intr_i),
        .jump_i       (jump),
        .jump_pc_i    (jump_pc),
        .trap_enter_i (trap_enter),
        .trap_ret_i   (trap_ret),
        .mtvec_i      (csr_mtvec_i),
        .mepc_i       (csr_mepc_i),
        .pc_o         (pc),
        .pc_next_o    (pc_next)
    );

    // read address is the next pc, like the sram address of the core
    imem_ram u_imem_ram (
        .clk     (clk),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .raddr_i (pc_next),
        .rdata_o (rdata)
    );

    fetch_stage u_fetch_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc_i    (pc),
        .rdata_i (rdata),
        .intr_i  (intr_i),
        .out     (fif.src)
    );

    predecode u_predecode (
        .clk           (clk),
        .rst_n         (rst_n),
        .in            (fif.dst),
        .jump_o        (jump),
        .jump_pc_o     (jump_pc),
        .trap_enter_o  (trap_enter),
        .trap_ret_o    (trap_ret),
        .out_valid_o   (out_valid_o),
        .out_pc_o      (out_pc_o),
        .out_instr_o   (out_instr_o),
        .out_is_jump_o (out_is_jump_o),
        .out_is_trap_o (out_is_trap_o)
    );

endmodule

// File: imem_ram.sv
`timescale 1ns/100ps

module imem_ram (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] waddr_i,
    input  logic [fetch_pkg::XLEN-1:0]   wdata_i,
    input  fetch_pkg::pc_t               raddr_i,
    output logic [fetch_pkg::XLEN-1:0]   rdata_o
);

    localparam int DEPTH = 2 ** fetch_pkg::IMEM_AW;

    logic [fetch_pkg::XLEN-1:0]    mem [DEPTH];
    logic [fetch_pkg::IMEM_AW-1:0] ridx;

    // word index from pc[10:3], upper bits wrap
    assign ridx = raddr_i[fetch_pkg::IMEM_AW+2:3];

    // load port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read data shows up the cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[ridx];
    end

endmodule

// File: pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           intr_i,
    input  logic           jump_i,
    input  fetch_pkg::pc_t jump_pc_i,
    input  logic           trap_enter_i,
    input  logic           trap_ret_i,
    input  fetch_pkg::pc_t mtvec_i,
    input  fetch_pkg::pc_t mepc_i,
    output fetch_pkg::pc_t pc_o,
    output fetch_pkg::pc_t pc_next_o
);

    fetch_pkg::pc_t pc_q;
    fetch_pkg::pc_t pc_next;

    // next pc, highest priority first
    always_comb begin
        if (intr_i) begin
            pc_next = mtvec_i;
        end else if (jump_i) begin
            pc_next = jump_pc_i;
        end else if (trap_enter_i) begin
            pc_next = mtvec_i;
        end else if (trap_ret_i) begin
            pc_next = mepc_i;
        end else begin
            pc_next = pc_q + fetch_pkg::pc_t'(4);
        end
    end

    // loads every cycle, nothing holds it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o      = pc_q;

    // also the memory read address
    assign pc_next_o = pc_next;

    // predecode decodes one instruction at a time, so at most one redirect
    a_one_redirect : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({jump_i, trap_enter_i, trap_ret_i})
    ) else $error("pc_gen: more than one redirect request in one cycle");

    // a jal target must stay on a 32-bit boundary, no compressed support
    a_jump_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        jump_i |-> (jump_pc_i[1:0] == 2'b00)
    ) else $error("pc_gen: misaligned jump target %h", jump_pc_i);

endmodule

// File: predecode.sv
`timescale 1ns/100ps

module predecode (
    input  logic                  clk,
    input  logic                  rst_n,
    fetch_if.dst                  in,
    output logic                  jump_o,
    output fetch_pkg::pc_t        jump_pc_o,
    output logic                  trap_enter_o,
    output logic                  trap_ret_o,
    output logic                  out_valid_o,
    output fetch_pkg::pc_t        out_pc_o,
    output fetch_pkg::inst_word_t out_instr_o,
    output logic                  out_is_jump_o,
    output logic                  out_is_trap_o
);

    fetch_pkg::inst_word_t word;
    fetch_pkg::pc_t        jal_off;
    logic                  is_jal;
    logic                  is_system;
    logic                  is_ecall;
    logic                  is_mret;
    logic                  redirect_ok;

    assign word = in.instr;

    // J-type view
    assign is_jal  = (word.j_fmt.opcode == fetch_pkg::OPC_JAL);
    assign jal_off = {{(fetch_pkg::XLEN-20){word.j_fmt.imm20}},
                      word.j_fmt.imm19_12,
                      word.j_fmt.imm11,
                      word.j_fmt.imm10_1,
                      1'b0};

    // I-type view, privileged SYSTEM with zero registers
    assign is_system = (word.i_fmt.opcode == fetch_pkg::OPC_SYSTEM)
                    && (word.i_fmt.funct3 == fetch_pkg::FUNCT3_PRIV)
                    && (word.i_fmt.rs1 == 5'd0)
                    && (word.i_fmt.rd == 5'd0);
    assign is_ecall  = is_system && (word.i_fmt.imm == fetch_pkg::FUNCT_ECALL);
    assign is_mret   = is_system && (word.i_fmt.imm == fetch_pkg::FUNCT_MRET);

    // an interrupt overrides whatever this instruction asks for
    assign redirect_ok = in.valid && !in.intr;

    assign jump_o       = redirect_ok && is_jal;
    assign jump_pc_o    = in.pc + jal_off;
    assign trap_enter_o = redirect_ok && is_ecall;
    assign trap_ret_o   = redirect_ok && is_mret;

    // output stream control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_o   <= 1'b0;
            out_is_jump_o <= 1'b0;
            out_is_trap_o <= 1'b0;
        end else begin
            out_valid_o   <= in.valid;
            out_is_jump_o <= in.valid && is_jal;
            out_is_trap_o <= in.valid && (is_ecall || is_mret);
        end
    end

    // payload only, meaningful while out_valid_o is high
    always_ff @(posedge clk) begin
        if (in.valid) begin
            out_pc_o    <= in.pc;
            out_instr_o <= word;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch -f vlog.f

out=$(./obj_dir/Vtb_fetch 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test OK"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tb_fetch.sv
`timescale 1ns/100ps

module tb_fetch;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int PROG_LEN        = 32;
    localparam int N_CHECK         = 400;
    localparam int N_QUIET         = 30;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_CHECK + 50;

    // first valid output 2 cycles after release, seen on the third sampling edge
    localparam int FIRST_VALID_EDGE = 3;

    localparam fetch_pkg::pc_t BOOT_PC = 64'h0000_0000_8000_0000;
    // handler at slot 24, trap return to slot 10
    localparam fetch_pkg::pc_t MTVEC   = BOOT_PC + 64'd96;
    localparam fetch_pkg::pc_t MEPC    = BOOT_PC + 64'd40;

    localparam logic [31:0] ECALL = 32'h0000_0073;
    localparam logic [31:0] MRET  = 32'h3020_0073;

    logic                          clk;
    logic                          rst_n;
    logic                          intr_i;
    fetch_pkg::pc_t                csr_mtvec_i;
    fetch_pkg::pc_t                csr_mepc_i;
    logic                          imem_we_i;
    logic [fetch_pkg::IMEM_AW-1:0] imem_waddr_i;
    logic [fetch_pkg::XLEN-1:0]    imem_wdata_i;
    logic                          out_valid_o;
    fetch_pkg::pc_t                out_pc_o;
    fetch_pkg::inst_word_t         out_instr_o;
    logic                          out_is_jump_o;
    logic                          out_is_trap_o;

    // program image, one entry per 32-bit slot from BOOT_PC
    logic [31:0]    shadow [PROG_LEN];

    fetch_pkg::pc_t model_pc   = BOOT_PC;
    logic           intr_d     = 1'b0;
    logic [31:0]    exp_word;
    logic           exp_jump;
    logic           exp_trap;
    int             cycles_up  = 0;
    int             checked    = 0;
    int             hits_jal   = 0;
    int             hits_ecall = 0;
    string          phase      = "reset_and_boot";

    fetch_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .intr_i        (intr_i),
        .csr_mtvec_i   (csr_mtvec_i),
        .csr_mepc_i    (csr_mepc_i),
        .imem_we_i     (imem_we_i),
        .imem_waddr_i  (imem_waddr_i),
        .imem_wdata_i  (imem_wdata_i),
        .out_valid_o   (out_valid_o),
        .out_pc_o      (out_pc_o),
        .out_instr_o   (out_instr_o),
        .out_is_jump_o (out_is_jump_o),
        .out_is_trap_o (out_is_trap_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] enc_addi(input int rd, input int imm);
        return {12'(imm), 5'd0, 3'b000, 5'(rd), 7'b0010011};
    endfunction

    // jal x0, offset
    function automatic logic [31:0] enc_jal(input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // interrupt first, then jal, ecall, mret, else the next slot
    function automatic fetch_pkg::pc_t next_pc(input fetch_pkg::pc_t pc,
                                               input logic [31:0] instr,
                                               input logic intr);
        logic [20:0]    joff;
        fetch_pkg::pc_t res;
        joff = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        if (intr) begin
            res = MTVEC;
        end else if (instr[6:0] == 7'b1101111) begin
            res = pc + {{43{joff[20]}}, joff};
        end else if (instr == ECALL) begin
            res = MTVEC;
        end else if (instr == MRET) begin
            res = MEPC;
        end else begin
            res = pc + 64'd4;
        end
        return res;
    endfunction

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_pc(input string what, input fetch_pkg::pc_t exp,
                            input fetch_pkg::pc_t act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", phase, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_instr(input string what, input fetch_pkg::inst_word_t exp,
                               input fetch_pkg::inst_word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", phase, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", phase, what, exp, act);
            fail_run();
        end
    endtask

    // an output at pc P means fetch now holds the slot after P,
    // so the strobe lands on the slot after that
    task automatic strobe_intr_after(input fetch_pkg::pc_t trigger_pc);
        bit seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = out_valid_o && (out_pc_o == trigger_pc);
        end
        intr_i <= 1'b1;
        @(posedge clk);
        intr_i <= 1'b0;
        repeat (6) @(posedge clk);
    endtask

    // reset, program load, then the stimulus phases
    initial begin
        logic [31:0] rng;
        bit          last;
        rng  = 32'h326d_c4c5;
        last = 1'b0;
        for (int s = 0; s < PROG_LEN; s++) begin
            shadow[5'(s)] = enc_addi(1, s);
        end
        // slots 5 to 7 are the wrong path behind the forward jal
        shadow[5'd4]  = enc_jal(16);
        shadow[5'd9]  = ECALL;
        shadow[5'd12] = enc_jal(-48);
        shadow[5'd25] = MRET;

        rst_n        = 1'b0;
        intr_i       = 1'b0;
        csr_mtvec_i  = MTVEC;
        csr_mepc_i   = MEPC;
        imem_we_i    = 1'b1;
        imem_waddr_i = '0;
        imem_wdata_i = {shadow[5'd1], shadow[5'd0]};
        for (int w = 1; w < RESET_CYCLES; w++) begin
            @(posedge clk);
            imem_waddr_i <= 8'(w);
            imem_wdata_i <= {shadow[5'(2 * w + 1)], shadow[5'(2 * w)]};
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        rst_n     <= 1'b1;

        phase <= "directed_program";
        while (checked < N_QUIET) begin
            @(posedge clk);
        end

        phase <= "intr_on_redirect";
        // backward jal at slot 12, forward jal at slot 4, ecall at slot 9
        strobe_intr_after(BOOT_PC + 64'd40);
        strobe_intr_after(BOOT_PC + 64'd8);
        strobe_intr_after(BOOT_PC + 64'd16);

        phase <= "random_intr";
        while (checked < N_CHECK) begin
            @(posedge clk);
            rng = lcg_next(rng);
            // one-cycle strobes, about one in four cycles
            last = !last && (rng[31:30] == 2'b00);
            intr_i <= last;
        end
        intr_i <= 1'b0;

        if (hits_jal >= 2 && hits_ecall >= 1) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("interrupt never landed on a jal and an ecall");
            fail_run();
        end
    end

    // compares each output with the reference model
    always @(posedge clk) begin
        if (rst_n) begin
            cycles_up = cycles_up + 1;
            check_flag("valid_timing", cycles_up >= FIRST_VALID_EDGE, out_valid_o);
            if (out_valid_o) begin
                exp_word = shadow[model_pc[6:2]];
                exp_jump = (exp_word[6:0] == 7'b1101111);
                exp_trap = (exp_word == ECALL) || (exp_word == MRET);
                check_pc("pc", model_pc, out_pc_o);
                check_instr("instr", exp_word, out_instr_o);
                check_flag("is_jump", exp_jump, out_is_jump_o);
                check_flag("is_trap", exp_trap, out_is_trap_o);
                if (intr_d && exp_jump) begin
                    hits_jal <= hits_jal + 1;
                end
                if (intr_d && exp_word == ECALL) begin
                    hits_ecall <= hits_ecall + 1;
                end
                // intr from the cycle this instruction sat in fetch
                model_pc = next_pc(model_pc, exp_word, intr_d);
                checked <= checked + 1;
            end
        end
        intr_d = intr_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: output stream stopped before %0d instructions were checked",
                 N_CHECK);
        fail_run();
    end

endmodule

// File: vlog.f
fetch_pkg.sv
fetch_if.sv
pc_gen.sv
imem_ram.sv
fetch_stage.sv
predecode.sv
fetch_top.sv
tb_fetch.sv
